/* exec_pkg.sv */
// Execute stage package
// Widths, operation and exception encodings, and the request structs

package exec_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int XLEN   = 32;
    localparam int TAG_W  = 3;
    localparam int STRB_W = XLEN / 8;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [STRB_W-1:0] strobe_t;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // Decoded operation from the decode stage
    typedef enum logic [4:0] {
        NOP,
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU,
        LUI,
        JAL, JALR,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        ECALL, EBREAK
    } op_e;

    typedef enum logic [1:0] {
        USER    = 2'b00,
        MACHINE = 2'b11
    } priv_e;

    // RISC-V mcause numbers
    typedef enum logic [3:0] {
        INST_MISALIGNED   = 4'd0,
        INST_ACCESS_FAULT = 4'd1,
        ILLEGAL_INST      = 4'd2,
        BREAKPOINT        = 4'd3,
        LOAD_ACCESS_FAULT = 4'd5,
        ECALL_U           = 4'd8,
        ECALL_M           = 4'd11
    } exc_code_e;

    // Idle code shares cause 0, exc_raise_o tells the two apart
    localparam exc_code_e NO_EXC = INST_MISALIGNED;

    ////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////

    // One instruction entering the stage
    typedef struct packed {
        word_t pc;
        word_t op1;
        word_t op2;
        word_t op3;     // Branch offset or store data
        op_e   op;
        tag_t  tag;
    } ex_req_t;

    typedef struct packed {
        word_t   addr;
        logic    read_en;
        strobe_t wstrb;
        word_t   wdata;
    } mem_req_t;

    // Faults flagged upstream
    typedef struct packed {
        logic illegal;
        logic misaligned;
        logic inst_fault;
        logic mem_fault;
    } fault_in_t;

endpackage

/* exec_alu.sv */
// Execute stage integer ALU
// Arithmetic, logic, shifts and compares with the registered result

`timescale 1ns/10ps

module exec_alu (
    input  logic              clk,
    input  logic              reset_n,
    input  exec_pkg::ex_req_t req_i,
    input  logic              stall_i,
    input  logic              retire_ok_i,
    output exec_pkg::word_t   sum_o,
    output exec_pkg::word_t   result_o,
    output logic              wen_o,
    output exec_pkg::op_e     op_o
);
    import exec_pkg::*;

    word_t       sum2_a;
    word_t       sum2_b;
    word_t       sum2;
    word_t       result;
    logic [4:0]  shamt;
    logic        lt;
    logic        ltu;
    logic        wen;

    ////////////////////////////////////////////////////////////
    // Adders and compares
    ////////////////////////////////////////////////////////////

    // Main adder also feeds the address and jump target
    assign sum_o = req_i.op1 + req_i.op2;

    // Second adder: op1 - op2 for SUB, link address otherwise
    assign sum2_a = (req_i.op == SUB) ? req_i.op1 : req_i.pc;
    assign sum2_b = (req_i.op == SUB) ? -req_i.op2 : word_t'(4);
    assign sum2   = sum2_a + sum2_b;

    assign shamt = req_i.op2[4:0];
    assign lt    = $signed(req_i.op1) < $signed(req_i.op2);
    assign ltu   = req_i.op1 < req_i.op2;

    ////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (req_i.op)
            SUB, JAL, JALR: result = sum2;
            AND:            result = req_i.op1 & req_i.op2;
            OR:             result = req_i.op1 | req_i.op2;
            XOR:            result = req_i.op1 ^ req_i.op2;
            SLL:            result = req_i.op1 << shamt;
            SRL:            result = req_i.op1 >> shamt;
            SRA:            result = $signed(req_i.op1) >>> shamt;
            SLT:            result = {{(XLEN-1){1'b0}}, lt};
            SLTU:           result = {{(XLEN-1){1'b0}}, ltu};
            LUI:            result = req_i.op2;
            // ADD and loads
            default:        result = sum_o;
        endcase
    end

    // Stores and branches write no register
    always_comb begin
        case (req_i.op)
            SB, SH, SW,
            BEQ, BNE, BLT, BLTU, BGE, BGEU: wen = 1'b0;
            default:                        wen = retire_ok_i;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_o <= '0;
            wen_o    <= 1'b0;
            op_o     <= NOP;
        end else if (!stall_i) begin
            result_o <= result;
            wen_o    <= wen;
            op_o     <= req_i.op;
        end
    end

    // Writeback decodes op_o, so it must stay known
    a_op_known: assert property (
        @(posedge clk) disable iff (!reset_n) !$isunknown(op_o)
    ) else $error("op_o unknown after reset");

endmodule

/* exec_branch.sv */
// Execute stage branch unit
// Evaluates branch conditions and computes the jump target

`timescale 1ns/10ps

module exec_branch (
    input  exec_pkg::ex_req_t req_i,
    input  exec_pkg::word_t   sum_i,
    output logic              taken_o,
    output exec_pkg::word_t   target_o
);
    import exec_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    ////////////////////////////////////////////////////////////
    // Conditions
    ////////////////////////////////////////////////////////////

    assign eq  = req_i.op1 == req_i.op2;
    assign lt  = $signed(req_i.op1) < $signed(req_i.op2);
    assign ltu = req_i.op1 < req_i.op2;

    always_comb begin
        case (req_i.op)
            BEQ:       taken_o = eq;
            BNE:       taken_o = !eq;
            BLT:       taken_o = lt;
            BLTU:      taken_o = ltu;
            BGE:       taken_o = !lt;
            BGEU:      taken_o = !ltu;
            JAL, JALR: taken_o = 1'b1;
            default:   taken_o = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Target
    ////////////////////////////////////////////////////////////

    // Kill is applied later in flow control
    always_comb begin
        case (req_i.op)
            JALR:    target_o = {sum_i[XLEN-1:1], 1'b0};
            JAL:     target_o = sum_i;
            // Conditional branches are PC relative
            default: target_o = req_i.pc + req_i.op3;
        endcase
    end

endmodule

/* exec_store_unit.sv */
// Execute stage load/store unit
// Word address, read enable, byte strobes and store data for the memory port

`timescale 1ns/10ps

module exec_store_unit (
    input  exec_pkg::ex_req_t  req_i,
    input  exec_pkg::word_t    sum_i,
    output exec_pkg::mem_req_t mem_o,
    output logic               mem_active_o
);
    import exec_pkg::*;

    logic [1:0] offset;

    assign offset = sum_i[1:0];

    // Memory is addressed by word
    assign mem_o.addr    = {sum_i[XLEN-1:2], 2'b00};
    assign mem_o.read_en = req_i.op inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////////////////////////////////
    // Byte strobes
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (req_i.op)
            SB:      mem_o.wstrb = strobe_t'(4'b0001 << offset);
            SH:      mem_o.wstrb = offset[1] ? 4'b1100 : 4'b0011;
            SW:      mem_o.wstrb = 4'b1111;
            default: mem_o.wstrb = 4'b0000;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Store data
    ////////////////////////////////////////////////////////////

    // Replicate so every lane carries the value
    always_comb begin
        case (req_i.op)
            SB:      mem_o.wdata = {4{req_i.op3[7:0]}};
            SH:      mem_o.wdata = {2{req_i.op3[15:0]}};
            default: mem_o.wdata = req_i.op3;
        endcase
    end

    // Any access qualifies the memory fault
    assign mem_active_o = mem_o.read_en || (mem_o.wstrb != '0);

    always_comb begin
        a_rw_exclusive: assert (!(mem_o.read_en && (mem_o.wstrb != '0)))
            else $error("read and write strobes active together");
    end

endmodule

/* exec_flow_ctrl.sv */
// Execute stage flow control
// Tag register, kill detection, jump qualification and exception priority

`timescale 1ns/10ps

module exec_flow_ctrl (
    input  logic                clk,
    input  logic                reset_n,
    input  exec_pkg::ex_req_t   req_i,
    input  exec_pkg::priv_e     priv_i,
    input  exec_pkg::fault_in_t fault_i,
    input  logic                taken_i,
    input  logic                mem_active_i,
    output logic                killed_o,
    output logic                jump_o,
    output logic                exc_raise_o,
    output exec_pkg::exc_code_e exc_code_o,
    output logic                retire_ok_o
);
    import exec_pkg::*;

    tag_t curr_tag;

    // Instruction from a stale flow
    assign killed_o = curr_tag != req_i.tag;

    ////////////////////////////////////////////////////////////
    // Exception priority
    ////////////////////////////////////////////////////////////

    always_comb begin
        exc_raise_o = 1'b0;
        exc_code_o  = NO_EXC;
        if (reset_n && !killed_o) begin
            exc_raise_o = 1'b1;
            if (fault_i.inst_fault) begin
                exc_code_o = INST_ACCESS_FAULT;
            end else if (fault_i.illegal) begin
                exc_code_o = ILLEGAL_INST;
            end else if (fault_i.misaligned) begin
                exc_code_o = INST_MISALIGNED;
            end else if (req_i.op == ECALL) begin
                exc_code_o = (priv_i == USER) ? ECALL_U : ECALL_M;
            end else if (req_i.op == EBREAK) begin
                exc_code_o = BREAKPOINT;
            end else if (fault_i.mem_fault && mem_active_i) begin
                exc_code_o = LOAD_ACCESS_FAULT;
            end else begin
                exc_raise_o = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Jump and retire
    ////////////////////////////////////////////////////////////

    // A trap wins over the jump, one tag step per flow change
    assign jump_o      = reset_n && taken_i && !killed_o && !exc_raise_o;
    assign retire_ok_o = !killed_o && !exc_raise_o;

    ////////////////////////////////////////////////////////////
    // Tag register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            curr_tag <= '0;
        end else if (jump_o || exc_raise_o) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

    a_jump_exc_excl: assert property (
        @(posedge clk) disable iff (!reset_n) !(jump_o && exc_raise_o)
    ) else $error("jump and exception raised together");

endmodule

/* exec_stage.sv */
// Execute stage top level
// Connects the ALU, branch, load/store and flow control units

`timescale 1ns/10ps

module exec_stage (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                stall_i,
    input  exec_pkg::ex_req_t   req_i,
    input  exec_pkg::priv_e     priv_i,
    input  exec_pkg::fault_in_t fault_i,
    output exec_pkg::word_t     result_o,
    output logic                wen_o,
    output exec_pkg::op_e       op_o,
    output exec_pkg::mem_req_t  mem_o,
    output logic                killed_o,
    output logic                jump_o,
    output exec_pkg::word_t     target_o,
    output logic                exc_raise_o,
    output exec_pkg::exc_code_e exc_code_o
);
    import exec_pkg::*;

    word_t sum;
    logic  taken;
    logic  mem_active;
    logic  retire_ok;

    exec_alu i_alu (
        .clk         (clk),
        .reset_n     (reset_n),
        .req_i       (req_i),
        .stall_i     (stall_i),
        .retire_ok_i (retire_ok),
        .sum_o       (sum),
        .result_o    (result_o),
        .wen_o       (wen_o),
        .op_o        (op_o)
    );

    exec_branch i_branch (
        .req_i    (req_i),
        .sum_i    (sum),
        .taken_o  (taken),
        .target_o (target_o)
    );

    exec_store_unit i_store_unit (
        .req_i        (req_i),
        .sum_i        (sum),
        .mem_o        (mem_o),
        .mem_active_o (mem_active)
    );

    exec_flow_ctrl i_flow_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .req_i        (req_i),
        .priv_i       (priv_i),
        .fault_i      (fault_i),
        .taken_i      (taken),
        .mem_active_i (mem_active),
        .killed_o     (killed_o),
        .jump_o       (jump_o),
        .exc_raise_o  (exc_raise_o),
        .exc_code_o   (exc_code_o),
        .retire_ok_o  (retire_ok)
    );

endmodule

/* tb_exec_vectors.svh */
// Stimulus and expected-value table for the execute stage testbench
// One row per cycle, applied in order

typedef struct {
    op_e       op;
    word_t     pc;
    word_t     op1;
    word_t     op2;
    word_t     op3;
    bit        stale;   // Row carries the previous tag and must be killed
    priv_e     priv;
    fault_in_t fault;
    bit        stall;
    bit        rnd;     // Random op1/op2, result comes from the model
    bit        jump;
    word_t     target;
    bit        raise;
    exc_code_e code;
    bit        rd;
    strobe_t   wstrb;
    word_t     wdata;
    word_t     addr;
    bit        wen;
    word_t     result;
} vec_t;

localparam int NUM_VEC = 42;

// op pc op1 op2 op3 stale priv fault stall rnd | jump target raise code
// | rd wstrb wdata addr | wen result
vec_t vectors [NUM_VEC] = '{
    '{ADD, 'h0, 'h0, 'h0, 'h0, 0, USER, 'b0, 0, 1, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'h0},
    '{SUB, 'h0, 'h0, 'h0, 'h0, 0, USER, 'b0, 0, 1, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'h0},
    '{AND, 'h0, 'h0, 'h0, 'h0, 0, USER, 'b0, 0, 1, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'h0},
    '{OR, 'h0, 'h0, 'h0, 'h0, 0, USER, 'b0, 0, 1, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'h0},
    '{XOR, 'h0, 'h0, 'h0, 'h0, 0, USER, 'b0, 0, 1, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'h0},
    '{SLL, 'h0, 'h0, 'h0, 'h0, 0, USER, 'b0, 0, 1, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'h0},
    '{SRL, 'h0, 'h0, 'h0, 'h0, 0, USER, 'b0, 0, 1, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'h0},
    '{SRA, 'h0, 'h0, 'h0, 'h0, 0, USER, 'b0, 0, 1, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'h0},
    '{SLT, 'h0, 'h0, 'h0, 'h0, 0, USER, 'b0, 0, 1, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'h0},
    '{SLTU, 'h0, 'h0, 'h0, 'h0, 0, USER, 'b0, 0, 1, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'h0},
    '{LUI, 'h0, 'h0, 'h12345000, 'h0, 0, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC,
      0, 'b0, 'h0, 'h0, 1, 'h12345000},
    // Stalled rows leave the registered outputs alone
    '{ADD, 'h0, 'h1, 'h2, 'h0, 0, USER, 'b0, 1, 0, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'h3},
    '{XOR, 'h0, 'hf, 'h3, 'h0, 0, USER, 'b0, 1, 0, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'hc},
    // Branches
    '{BEQ, 'h100, 'h5, 'h5, 'h40, 0, USER, 'b0, 0, 0, 1, 'h140, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 0, 'ha},
    '{BNE, 'h100, 'h5, 'h5, 'h40, 0, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 0, 'ha},
    '{BLT, 'h200, 'hffffffff, 'h1, 'hfffffff0, 0, USER, 'b0, 0, 0, 1, 'h1f0, 0, NO_EXC,
      0, 'b0, 'h0, 'h0, 0, 'h0},
    '{BLTU, 'h200, 'hffffffff, 'h1, 'h10, 0, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC,
      0, 'b0, 'h0, 'h0, 0, 'h0},
    '{BGE, 'h200, 'hffffffff, 'h1, 'h10, 0, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC,
      0, 'b0, 'h0, 'h0, 0, 'h0},
    '{BGEU, 'h300, 'hffffffff, 'h1, 'h8, 0, USER, 'b0, 0, 0, 1, 'h308, 0, NO_EXC,
      0, 'b0, 'h0, 'h0, 0, 'h0},
    '{JAL, 'h400, 'h400, 'h20, 'h0, 0, USER, 'b0, 0, 0, 1, 'h420, 0, NO_EXC,
      0, 'b0, 'h0, 'h0, 1, 'h404},
    '{JALR, 'h500, 'h1001, 'h4, 'h0, 0, USER, 'b0, 0, 0, 1, 'h1004, 0, NO_EXC,
      0, 'b0, 'h0, 'h0, 1, 'h504},
    // Stale flow, then the new flow
    '{ADD, 'h0, 'h1, 'h2, 'h0, 1, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 0, 'h3},
    '{JAL, 'h600, 'h600, 'h8, 'h0, 1, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC,
      0, 'b0, 'h0, 'h0, 0, 'h604},
    '{ADD, 'h0, 'h7, 'h8, 'h0, 0, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'hf},
    // Stores and loads
    '{SB, 'h0, 'h1000, 'h1, 'ha5, 0, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC,
      0, 'b0010, 'ha5a5a5a5, 'h1000, 0, 'h1001},
    '{SB, 'h0, 'h1000, 'h3, 'h1234, 0, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC,
      0, 'b1000, 'h34343434, 'h1000, 0, 'h1003},
    '{SH, 'h0, 'h2000, 'h2, 'h1234beef, 0, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC,
      0, 'b1100, 'hbeefbeef, 'h2000, 0, 'h2002},
    '{SH, 'h0, 'h2000, 'h0, 'h1234beef, 0, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC,
      0, 'b0011, 'hbeefbeef, 'h2000, 0, 'h2000},
    '{SW, 'h0, 'h3000, 'h4, 'hdeadbeef, 0, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC,
      0, 'b1111, 'hdeadbeef, 'h3004, 0, 'h3004},
    '{LW, 'h0, 'h4000, 'h8, 'h0, 0, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC,
      1, 'b0, 'h0, 'h4008, 1, 'h4008},
    '{LBU, 'h0, 'h4000, 'h13, 'h0, 0, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC,
      1, 'b0, 'h0, 'h4010, 1, 'h4013},
    // Exception priority
    '{ADD, 'h0, 'h1, 'h1, 'h0, 0, USER, 'b1111, 0, 0, 0, 'h0, 1, INST_ACCESS_FAULT,
      0, 'b0, 'h0, 'h0, 0, 'h2},
    '{ADD, 'h0, 'h1, 'h1, 'h0, 0, USER, 'b1101, 0, 0, 0, 'h0, 1, ILLEGAL_INST,
      0, 'b0, 'h0, 'h0, 0, 'h2},
    '{ECALL, 'h0, 'h0, 'h0, 'h0, 0, USER, 'b0100, 0, 0, 0, 'h0, 1, INST_MISALIGNED,
      0, 'b0, 'h0, 'h0, 0, 'h0},
    '{ECALL, 'h0, 'h0, 'h0, 'h0, 0, USER, 'b0, 0, 0, 0, 'h0, 1, ECALL_U, 0, 'b0, 'h0, 'h0, 0, 'h0},
    '{ECALL, 'h0, 'h0, 'h0, 'h0, 0, MACHINE, 'b0001, 0, 0, 0, 'h0, 1, ECALL_M,
      0, 'b0, 'h0, 'h0, 0, 'h0},
    '{EBREAK, 'h0, 'h0, 'h0, 'h0, 0, USER, 'b0001, 0, 0, 0, 'h0, 1, BREAKPOINT,
      0, 'b0, 'h0, 'h0, 0, 'h0},
    '{LW, 'h0, 'h5000, 'h4, 'h0, 0, USER, 'b0001, 0, 0, 0, 'h0, 1, LOAD_ACCESS_FAULT,
      1, 'b0, 'h0, 'h5004, 0, 'h5004},
    '{ADD, 'h0, 'h2, 'h3, 'h0, 0, USER, 'b0001, 0, 0, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'h5},
    '{ECALL, 'h0, 'h0, 'h0, 'h0, 1, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 0, 'h0},
    // Trap suppresses the jump
    '{JAL, 'h700, 'h700, 'h10, 'h0, 0, USER, 'b1000, 0, 0, 0, 'h0, 1, ILLEGAL_INST,
      0, 'b0, 'h0, 'h0, 0, 'h704},
    '{ADD, 'h0, 'h10, 'h20, 'h0, 0, USER, 'b0, 0, 0, 0, 'h0, 0, NO_EXC, 0, 'b0, 'h0, 'h0, 1, 'h30}
};

/* tb_exec_stage.sv */
// Testbench for the execute stage
// Applies the vector table one row per cycle and checks every output

`timescale 1ns/10ps

module tb_exec_stage;
    import exec_pkg::*;

    `include "tb_exec_vectors.svh"

    logic      clk;
    logic      reset_n;
    logic      stall;
    ex_req_t   req;
    priv_e     priv;
    fault_in_t fault;
    word_t     result;
    logic      wen;
    op_e       op_q;
    mem_req_t  mem;
    logic      killed;
    logic      jump;
    word_t     target;
    logic      exc_raise;
    exc_code_e exc_code;

    int        errors;
    int        seed;
    tag_t      tag_model;
    word_t     held_result;
    logic      held_wen;
    op_e       held_op;

    exec_stage i_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .stall_i     (stall),
        .req_i       (req),
        .priv_i      (priv),
        .fault_i     (fault),
        .result_o    (result),
        .wen_o       (wen),
        .op_o        (op_q),
        .mem_o       (mem),
        .killed_o    (killed),
        .jump_o      (jump),
        .target_o    (target),
        .exc_raise_o (exc_raise),
        .exc_code_o  (exc_code)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge clk);
        #10 reset_n = 1'b1;
    end

    // Guard against a hung run
    initial begin
        #100000;
        $display("ERROR: simulation did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Reference ALU written from the instruction definitions
    function automatic word_t alu_ref(input op_e op, input word_t a, input word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return word_t'($signed(a) >>> b[4:0]);
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (a < b) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic check_registered();
        check_value("result_o", result, held_result);
        check_value("wen_o", wen, held_wen);
        check_value("op_o", op_q, held_op);
    endtask

    ////////////////////////////////////////////////////////////
    // Vector loop
    ////////////////////////////////////////////////////////////

    task automatic apply_vectors();
        vec_t  v;
        word_t a;
        word_t b;
        word_t exp_res;
        for (int i = 0; i < NUM_VEC; i++) begin
            @(posedge clk);
            #10;
            if (i > 0) check_registered();
            v = vectors[i];
            a = v.op1;
            b = v.op2;
            exp_res = v.result;
            if (v.rnd) begin
                a = $random(seed);
                b = $random(seed);
                exp_res = alu_ref(v.op, a, b);
            end
            req.pc  = v.pc;
            req.op1 = a;
            req.op2 = b;
            req.op3 = v.op3;
            req.op  = v.op;
            req.tag = v.stale ? tag_t'(tag_model - 1'b1) : tag_model;
            priv    = v.priv;
            fault   = v.fault;
            stall   = v.stall;
            if (!v.stall) begin
                held_result = exp_res;
                held_wen    = v.wen;
                held_op     = v.op;
            end
            #40;
            check_value("killed_o", killed, v.stale);
            check_value("jump_o", jump, v.jump);
            check_value("exc_raise_o", exc_raise, v.raise);
            check_value("exc_code_o", exc_code, v.code);
            if (v.jump) check_value("target_o", target, v.target);
            if (v.rd || v.wstrb != '0) begin
                check_value("mem addr", mem.addr, v.addr);
                check_value("mem read_en", mem.read_en, v.rd);
                check_value("mem wstrb", mem.wstrb, v.wstrb);
                check_value("mem wdata", mem.wdata, v.wdata);
            end
            // Flow changes move the tag on
            if (v.jump || v.raise) tag_model = tag_model + 1'b1;
        end
        @(posedge clk);
        #10;
        check_registered();
    endtask

    initial begin
        int cycles;
        errors      = 0;
        seed        = 44;
        tag_model   = '0;
        held_result = '0;
        held_wen    = 1'b0;
        held_op     = NOP;
        stall       = 1'b0;
        req         = '0;
        priv        = USER;
        fault       = '0;

        // No trap or jump may leave the stage while in reset
        #160;
        req.op = ECALL;
        #40;
        check_value("exc_raise_o in reset", exc_raise, 1'b0);
        #60;
        req.op = JAL;
        #40;
        check_value("jump_o in reset", jump, 1'b0);
        #60;
        req.op = NOP;

        cycles = 0;
        while (reset_n !== 1'b1 && cycles < 400) begin
            #10;
            cycles++;
        end
        if (reset_n !== 1'b1) begin
            $display("ERROR: reset was never released");
            errors++;
        end else begin
            check_value("result_o after reset", result, 32'h0);
            check_value("wen_o after reset", wen, 1'b0);
            check_value("op_o after reset", op_q, NOP);
            apply_vectors();
        end

        $display("Tests done with %0d errors", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+.
exec_pkg.sv
exec_alu.sv
exec_branch.sv
exec_store_unit.sv
exec_flow_ctrl.sv
exec_stage.sv
tb_exec_stage.sv

/* run.sh */
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_exec_stage \
    -Mdir obj_dir && ./obj_dir/Vtb_exec_stage)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "PASS: all tests" && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}
